/* sim/csb_input.txt */
# First the command count, then per command eight words, outputs and final burst address
# Last line holds the expected retired and skipped command totals, all values hex
5
00040101 00040004 00200010 00030204
00040010 00002000 00001000 00003000
0008 00000540
00080204 00080008 00100010 00020306
00090024 00005000 00004000 00006000
0009 00001240
00010100 00010001 00100010 00010101
00010001 00007000 00008000 00009000
0000 00002000
00020105 00020002 00100010 00020101
00010001 0000a000 00000100 0000b000
0001 00000060
00010106 00010001 00100010 00010101
00010001 0000c000 00000200 0000d000
0000 00000080
0003 0002

/* tb.f */
+incdir+common
common/csb_pkg.sv
common/csb_cmd_if.sv
hdl/cmd_fifo.sv
csb/csb_decode.sv
csb/csb_execute.sv
csb/csb_result.sv
hdl/csb_top.sv
sim/tb_csb.sv

/* sim/tb_csb.sv */
`timescale 1ns/100ps
`include "csb_settings.svh"

module tb_csb;
    import csb_pkg::*;

    localparam int MAX_CMDS = 8;
    localparam int TIMEOUT  = 2000;    // Cycles allowed for any single wait

    logic clk, rst, i_op_en, i_cmd_wr, o_cmd_full;
    cmd_word_t i_cmd_data;
    logic i_conv_valid, i_maxpool_valid, i_avepool_valid;
    logic o_conv_ready, o_maxpool_ready, o_avepool_ready, o_engine_reset, o_irq;
    burst_addr_t o_data_addr, o_weight_addr;
    mem_addr_t o_result_addr;
    count16_t o_op_num, o_cmd_count, o_skip_count, o_out_count;
    side_t o_kernel_size, o_side_size;

    cmd_word_t words [MAX_CMDS*8];          // Command words from the data file
    count16_t exp_out [MAX_CMDS];
    burst_addr_t exp_final [MAX_CMDS];
    count16_t total_cmd, total_skip, total_out;
    int n_cmds, errors, tests_ok, tests_bad, collected;
    int seed = 32'h393f_8239;
    int gap = 0;
    logic r_conv, r_max, r_ave;            // Readies seen at the last falling edge

    csb_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(negedge clk) begin
        r_conv <= o_conv_ready;
        r_max  <= o_maxpool_ready;
        r_ave  <= o_avepool_ready;
    end

    // Engine model with random gaps and stray pulses at idle engines
    always @(posedge clk) begin
        i_conv_valid    <= 1'b0;
        i_maxpool_valid <= 1'b0;
        i_avepool_valid <= 1'b0;
        if (r_conv || r_max || r_ave) begin
            if (gap == 0) begin
                if (r_conv) i_conv_valid <= 1'b1;
                if (r_max)  i_maxpool_valid <= 1'b1;
                if (r_ave)  i_avepool_valid <= 1'b1;
                gap = {$random(seed)} % 4;
            end else begin
                gap = gap - 1;
                if ({$random(seed)} % 2 == 0) begin    // Lone pulse, engine not enabled
                    if (r_conv) i_avepool_valid <= 1'b1;
                    else        i_conv_valid    <= 1'b1;
                end
            end
        end
    end

    task automatic check_addr(input burst_addr_t got, input burst_addr_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input count16_t got, input count16_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic give_up(input string what);
        $display("Timed out at %0t while waiting for %s", $time, what);
        $display("Verification failed");
        $finish;
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: FAILED with %0d errors", name, errors - err_before);
        end
    endtask

    task automatic load_file();
        int fd;
        string skip_line;
        fd = $fopen("sim/csb_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open sim/csb_input.txt");
            $display("Verification failed");
            $finish;
        end else begin
            void'($fgets(skip_line, fd));       // Two comment lines on top
            void'($fgets(skip_line, fd));
            void'($fscanf(fd, "%h", n_cmds));
            for (int k = 0; k < n_cmds; k++) begin
                for (int i = 0; i < 8; i++)
                    void'($fscanf(fd, "%h", words[k*8+i]));
                void'($fscanf(fd, "%h %h", exp_out[k], exp_final[k]));
            end
            void'($fscanf(fd, "%h %h", total_cmd, total_skip));
            $fclose(fd);
        end
    endtask

    // Host side, keeps at most four commands ahead of the sequencer
    initial begin
        int t;
        @(negedge rst);
        for (int k = 0; k < n_cmds; k++) begin
            t = 0;
            while (k >= collected + 4) begin
                @(posedge clk);
                t++;
                if (t > TIMEOUT) give_up("room in the command FIFO");
            end
            for (int i = 0; i < 8; i++) begin
                @(posedge clk);
                i_cmd_wr   <= 1'b1;
                i_cmd_data <= words[k*8+i];
            end
            @(posedge clk);
            i_cmd_wr <= 1'b0;
        end
    end

    task automatic run_command(input int k);
        cmd_word_t w0;
        op_type_t op;
        logic want_conv, want_max, want_ave, is_skip, seen, done;
        count16_t out0, skip0, last_cnt, scnt;
        side_t wcnt;
        burst_addr_t model;
        int t, err0;
        w0 = words[k*8];
        op = w0[2:0];
        want_conv = (op >= 3'd1) && (op <= 3'd3);
        want_max = (op == 3'd4);
        want_ave = (op == 3'd5);
        is_skip = !(want_conv || want_max || want_ave);
        err0 = errors;
        t = 0;
        while (!o_engine_reset) begin       // Back to collect first
            @(negedge clk);
            t++;
            if (t > TIMEOUT) give_up("the sequencer to collect");
        end
        t = 0;
        while (o_engine_reset) begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) give_up("a command to issue");
        end
        collected++;
        out0 = o_out_count;
        skip0 = o_skip_count;
        last_cnt = out0;
        model = words[k*8+6][31:2];
        wcnt = '0;
        scnt = '0;
        seen = 1'b0;
        done = 1'b0;
        t = 0;
        while (!done) begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) give_up("the end of a layer operation");
            check_flag(o_conv_ready && !want_conv, 1'b0, "conv ready for this op");
            check_flag(o_maxpool_ready && !want_max, 1'b0, "max pool ready for this op");
            check_flag(o_avepool_ready && !want_ave, 1'b0, "ave pool ready for this op");
            if (o_out_count != last_cnt) begin      // One output accepted
                if (wcnt + 8'd1 == words[k*8+3][15:8]) begin
                    model = model + {words[k*8][31:16], 4'h0};     // Next row
                    wcnt = '0;
                end else begin
                    model = model + {w0[11:8], 4'h0};
                    wcnt = wcnt + 8'd1;
                end
                scnt = scnt + 16'd1;
                if (scnt == words[k*8+4][31:16]) begin
                    scnt = '0;
                    wcnt = '0;
                end
                last_cnt = o_out_count;
            end
            if (o_conv_ready || o_maxpool_ready || o_avepool_ready) begin
                seen = 1'b1;
                check_addr(o_data_addr, model, "data address");
            end else if (is_skip) begin
                done = (o_skip_count != skip0);
            end else begin
                done = seen;
            end
        end
        check_flag(seen, !is_skip, "engine ready raised");
        check_count(o_out_count - out0, exp_out[k], "outputs of this command");
        check_count(o_skip_count - skip0, count16_t'(is_skip), "skip count step");
        check_addr(model, exp_final[k], "model final address against file");
        check_addr(o_data_addr, exp_final[k], "final data address");
        check_addr(o_weight_addr, words[k*8+5][31:2], "weight address");
        check_addr(o_result_addr[31:2], words[k*8+7][31:2], "result address");
        check_count(count16_t'(o_kernel_size), count16_t'(words[k*8+3][23:16]), "kernel size");
        check_count(count16_t'(o_side_size), count16_t'(words[k*8+3][15:8]), "output side");
        check_count(o_op_num, words[k*8][31:16], "op_num");
        report_test($sformatf("command %0d op %0d", k, op), err0);
    endtask

    initial begin
        int t, err0;
        rst <= 1'b1;
        i_op_en <= 1'b0;
        i_cmd_wr <= 1'b0;
        i_cmd_data <= '0;
        i_conv_valid <= 1'b0;
        i_maxpool_valid <= 1'b0;
        i_avepool_valid <= 1'b0;
        errors = 0;
        tests_ok = 0;
        tests_bad = 0;
        collected = 0;
        total_out = '0;
        load_file();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        err0 = errors;
        check_flag(o_irq, 1'b0, "irq after reset");
        check_flag(o_conv_ready | o_maxpool_ready | o_avepool_ready, 1'b0, "readies after reset");
        check_flag(o_engine_reset, 1'b1, "engine reset after reset");
        report_test("reset state", err0);
        @(posedge clk);
        i_op_en <= 1'b1;
        for (int k = 0; k < n_cmds; k++) begin
            run_command(k);
            total_out = total_out + exp_out[k];
        end
        err0 = errors;
        t = 0;
        while (!o_irq) begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) give_up("the interrupt");
        end
        repeat (5) begin                    // Interrupt is sticky
            @(negedge clk);
            check_flag(o_irq, 1'b1, "irq held")
;
        end
        check_count(o_cmd_count, total_cmd, "retired commands");
        check_count(o_skip_count, total_skip, "skipped commands");
        check_count(o_out_count, total_out, "total outputs");
        report_test("interrupt and totals", err0);
        // Sequencer sits in finish, so nothing drains the FIFO any more
        err0 = errors;
        for (int i = 0; i < `CSB_FIFO_DEPTH; i++) begin
            @(negedge clk);
            check_flag(o_cmd_full, 1'b0, "full flag before the FIFO holds its depth");
            @(posedge clk);
            i_cmd_wr   <= 1'b1;
            i_cmd_data <= {16'hf1f0, 16'(i)};
        end
        @(posedge clk);
        i_cmd_wr <= 1'b0;
        @(negedge clk);
        check_flag(o_cmd_full, 1'b1, "full flag with the FIFO at its depth");
        report_test("command fifo full", err0);
        $display("tests passed %0d, failed %0d", tests_ok, tests_bad);
        if (tests_bad == 0 && errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

/* hdl/csb_top.sv */
`timescale 1ns/100ps

module csb_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_op_en,
    input  logic                    i_cmd_wr,
    input  csb_pkg::cmd_word_t      i_cmd_data,
    output logic                    o_cmd_full,
    input  logic                    i_conv_valid,
    input  logic                    i_maxpool_valid,
    input  logic                    i_avepool_valid,
    output logic                    o_conv_ready,
    output logic                    o_maxpool_ready,
    output logic                    o_avepool_ready,
    output csb_pkg::burst_addr_t    o_data_addr,
    output csb_pkg::burst_addr_t    o_weight_addr,
    output csb_pkg::mem_addr_t      o_result_addr,
    output csb_pkg::count16_t       o_op_num,
    output csb_pkg::side_t          o_kernel_size,
    output csb_pkg::side_t          o_side_size,
    output logic                    o_engine_reset,
    output csb_pkg::count16_t       o_cmd_count,
    output csb_pkg::count16_t       o_skip_count,
    output csb_pkg::count16_t       o_out_count,
    output logic                    o_irq
);
    import csb_pkg::*;

    cmd_word_t  fifo_data;
    fifo_cnt_t  fifo_count;
    logic       fifo_empty;
    logic       fifo_rd;
    logic       out_pulse;      // One per accepted output pixel
    logic       finished;

    csb_cmd_if cmd_bus ();      // Decoded command, decode to execute

    cmd_fifo fifo_i (
        .clk(clk), .rst(rst),
        .i_wr(i_cmd_wr), .i_wdata(i_cmd_data), .i_rd(fifo_rd),
        .o_rdata(fifo_data), .o_count(fifo_count), .o_empty(fifo_empty), .o_full(o_cmd_full)
    );

    csb_decode dec_i (
        .clk(clk), .rst(rst), .i_op_en(i_op_en),
        .i_fifo_data(fifo_data), .i_fifo_count(fifo_count), .i_fifo_empty(fifo_empty),
        .o_fifo_rd(fifo_rd), .o_engine_reset(o_engine_reset), .o_finished(finished),
        .cmd(cmd_bus.dec)
    );

    csb_execute exe_i (
        .clk(clk), .rst(rst), .cmd(cmd_bus.exe),
        .i_conv_valid(i_conv_valid), .i_maxpool_valid(i_maxpool_valid),
        .i_avepool_valid(i_avepool_valid),
        .o_conv_ready(o_conv_ready), .o_maxpool_ready(o_maxpool_ready),
        .o_avepool_ready(o_avepool_ready),
        .o_data_addr(o_data_addr), .o_weight_addr(o_weight_addr), .o_result_addr(o_result_addr),
        .o_op_num(o_op_num), .o_kernel_size(o_kernel_size), .o_side_size(o_side_size),
        .o_out_pulse(out_pulse)
    );

    csb_result res_i (
        .clk(clk), .rst(rst),
        .i_out_pulse(out_pulse), .i_op_done(cmd_bus.op_done), .i_skipped(cmd_bus.skipped),
        .i_finished(finished),
        .o_cmd_count(o_cmd_count), .o_skip_count(o_skip_count), .o_out_count(o_out_count),
        .o_irq(o_irq)
    );

endmodule

/* csb/csb_result.sv */
`timescale 1ns/100ps

module csb_result (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_out_pulse,
    input  logic                i_op_done,
    input  logic                i_skipped,
    input  logic                i_finished,
    output csb_pkg::count16_t   o_cmd_count,
    output csb_pkg::count16_t   o_skip_count,
    output csb_pkg::count16_t   o_out_count,
    output logic                o_irq
);
    import csb_pkg::*;

    count16_t cmd_cnt;
    count16_t skip_cnt;
    count16_t out_cnt;
    logic     irq;

    // Tallies since reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd_cnt  <= '0;
            skip_cnt <= '0;
            out_cnt  <= '0;
            irq      <= 1'b0;
        end else begin
            if (i_op_done && !i_skipped)
                cmd_cnt <= cmd_cnt + 16'd1;     // Layer fully computed
            if (i_op_done && i_skipped)
                skip_cnt <= skip_cnt + 16'd1;   // Bad op code passed over
            if (i_out_pulse)
                out_cnt <= out_cnt + 16'd1;
            if (i_finished)
                irq <= 1'b1;                    // Sticky until reset
        end
    end

    assign o_cmd_count  = cmd_cnt;
    assign o_skip_count = skip_cnt;
    assign o_out_count  = out_cnt;
    assign o_irq        = irq;

endmodule

/* csb/csb_execute.sv */
`timescale 1ns/100ps
`include "csb_settings.svh"

module csb_execute (
    input  logic                    clk,
    input  logic                    rst,
    csb_cmd_if.exe                  cmd,
    input  logic                    i_conv_valid,
    input  logic                    i_maxpool_valid,
    input  logic                    i_avepool_valid,
    output logic                    o_conv_ready,
    output logic                    o_maxpool_ready,
    output logic                    o_avepool_ready,
    output csb_pkg::burst_addr_t    o_data_addr,
    output csb_pkg::burst_addr_t    o_weight_addr,
    output csb_pkg::mem_addr_t      o_result_addr,
    output csb_pkg::count16_t       o_op_num,
    output csb_pkg::side_t          o_kernel_size,
    output csb_pkg::side_t          o_side_size,
    output logic                    o_out_pulse
);
    import csb_pkg::*;

    side_t      width_cnt;      // Pixel within the current row
    count16_t   surf_cnt;       // Pixels done in this channel group
    count16_t   chan_cnt;       // First channel of the current group
    logic       acc;
    logic       row_end;
    logic       surf_end;
    logic       last_out;

    // Only the engine that holds ready is listened to
    assign acc = (o_conv_ready    & i_conv_valid)    |
                 (o_maxpool_ready & i_maxpool_valid) |
                 (o_avepool_ready & i_avepool_valid);
    assign o_out_pulse = acc;

    assign row_end  = (width_cnt + 8'd1) == cmd.o_side_size;
    assign surf_end = (surf_cnt + 16'd1) == cmd.o_surf_size;
    assign last_out = surf_end && ((chan_cnt + count16_t'(`CSB_PARA)) == cmd.o_channel_size);

    // Engine select, position counters and completion
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_conv_ready    <= 1'b0;
            o_maxpool_ready <= 1'b0;
            o_avepool_ready <= 1'b0;
            cmd.op_done     <= 1'b0;
            cmd.skipped     <= 1'b0;
            width_cnt       <= '0;
            surf_cnt        <= '0;
            chan_cnt        <= '0;
        end else begin
            cmd.op_done <= 1'b0;                    // Single-cycle pulse
            if (cmd.start) begin
                width_cnt   <= '0;
                surf_cnt    <= '0;
                chan_cnt    <= '0;
                cmd.skipped <= 1'b0;
                case (cmd.op_type)
                    3'd1, 3'd2, 3'd3: o_conv_ready    <= 1'b1;
                    3'd4:             o_maxpool_ready <= 1'b1;
                    3'd5:             o_avepool_ready <= 1'b1;
                    default: begin                  // Unknown op, retire it at once
                        cmd.op_done <= 1'b1;
                        cmd.skipped <= 1'b1;
                    end
                endcase
            end else if (acc) begin
                surf_cnt <= surf_cnt + 16'd1;
                if (row_end)
                    width_cnt <= '0;
                else
                    width_cnt <= width_cnt + 8'd1;
                if (surf_end) begin                 // Next group of channels
                    chan_cnt  <= chan_cnt + count16_t'(`CSB_PARA);
                    surf_cnt  <= '0;
                    width_cnt <= '0;
                end
                if (last_out) begin
                    o_conv_ready    <= 1'b0;
                    o_maxpool_ready <= 1'b0;
                    o_avepool_ready <= 1'b0;
                    cmd.op_done     <= 1'b1;
                end
            end
        end
    end

    // Address generation and latched command fields
    always_ff @(posedge clk) begin
        if (cmd.start) begin
            o_data_addr   <= cmd.data_addr[31:2];
            o_weight_addr <= cmd.weight_addr[31:2];
            o_result_addr <= cmd.result_addr;
            o_op_num      <= cmd.op_num;
            o_kernel_size <= cmd.kernel_size;
            o_side_size   <= cmd.o_side_size;
        end else if (acc) begin
            if (row_end)
                o_data_addr <= o_data_addr + {10'd0, cmd.op_num, 4'h0};    // Jump to next row
            else
                o_data_addr <= o_data_addr + {22'd0, cmd.stride, 4'h0};    // Stride step
        end
    end

endmodule

/* csb/csb_decode.sv */
`timescale 1ns/100ps
`include "csb_settings.svh"

module csb_decode (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_op_en,
    input  csb_pkg::cmd_word_t  i_fifo_data,
    input  csb_pkg::fifo_cnt_t  i_fifo_count,
    input  logic                i_fifo_empty,
    output logic                o_fifo_rd,
    output logic                o_engine_reset,
    output logic                o_finished,
    csb_cmd_if.dec              cmd
);
    import csb_pkg::*;

    csb_state_t state;
    csb_state_t next_state;
    logic [3:0] rd_cnt;         // Reads issued for this command, 0 to 8
    logic       rd_dly;         // FIFO output holds a fresh word
    logic [2:0] rd_idx;         // Which word of the command that is
    logic       last_word;

    // Start reading only once a whole command sits in the FIFO, then run all eight
    assign o_fifo_rd = (state == collect) && (rd_cnt < 4'(`CSB_CMD_WORDS)) &&
                       ((rd_cnt != 4'd0) || (i_fifo_count >= fifo_cnt_t'(`CSB_CMD_WORDS)));

    assign last_word      = rd_dly && (rd_idx == 3'(`CSB_CMD_WORDS - 1));
    assign o_engine_reset = (state == idle) || (state == collect);
    assign o_finished     = (state == finish);

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            state <= idle;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            idle:    if (i_op_en) next_state = collect;
            collect: if (last_word) next_state = issue;
            issue:   next_state = wait_op;              // Start is out this cycle
            wait_op: begin
                if (cmd.op_done)
                    next_state = i_fifo_empty ? finish : collect;
            end
            finish:  next_state = finish;               // Only reset leaves
            default: next_state = idle;
        endcase
    end

    // Read sequencing and the start pulse
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_cnt    <= '0;
            rd_dly    <= 1'b0;
            rd_idx    <= '0;
            cmd.start <= 1'b0;
        end else begin
            if (state != collect)
                rd_cnt <= '0;                   // Fresh count for the next command
            else if (o_fifo_rd)
                rd_cnt <= rd_cnt + 4'd1;
            rd_dly    <= o_fifo_rd;
            rd_idx    <= rd_cnt[2:0];
            cmd.start <= (state == collect) && last_word;   // High during issue
        end
    end

    // Word parser, fields stay put until the next collect
    always_ff @(posedge clk) begin
        if (rd_dly) begin
            case (rd_idx)
                3'd0: begin
                    cmd.op_type <= i_fifo_data[2:0];
                    cmd.stride  <= i_fifo_data[11:8];
                    cmd.op_num  <= i_fifo_data[31:16];
                end
                3'd1: ;                         // Corner and side op_num copies
                3'd2: cmd.o_channel_size <= i_fifo_data[31:16];
                3'd3: begin
                    cmd.o_side_size <= i_fifo_data[15:8];
                    cmd.kernel_size <= i_fifo_data[23:16];
                end
                3'd4: cmd.o_surf_size <= i_fifo_data[31:16];
                3'd5: cmd.weight_addr <= i_fifo_data;
                3'd6: cmd.data_addr   <= i_fifo_data;
                3'd7: cmd.result_addr <= i_fifo_data;
                default: ;
            endcase
        end
    end

endmodule

/* hdl/cmd_fifo.sv */
`timescale 1ns/100ps
`include "csb_settings.svh"

module cmd_fifo (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_wr,
    input  csb_pkg::cmd_word_t  i_wdata,
    input  logic                i_rd,
    output csb_pkg::cmd_word_t  o_rdata,
    output csb_pkg::fifo_cnt_t  o_count,
    output logic                o_empty,
    output logic                o_full
);
    import csb_pkg::*;

    cmd_word_t              mem [`CSB_FIFO_DEPTH];     // Circular storage
    logic [`CSB_FIFO_AW-1:0] wr_ptr;
    logic [`CSB_FIFO_AW-1:0] rd_ptr;
    fifo_cnt_t              count;
    logic                   wr_en;
    logic                   rd_en;

    assign o_empty = (count == '0);
    assign o_full  = (count == fifo_cnt_t'(`CSB_FIFO_DEPTH));
    assign o_count = count;

    assign wr_en = i_wr & ~o_full;      // Write to a full FIFO is lost
    assign rd_en = i_rd & ~o_empty;     // Read of an empty FIFO keeps old data

    // Pointers and fill level
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;    // Wraps at depth
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Both or neither
            endcase
        end
    end

    // Storage and registered read port
    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_ptr] <= i_wdata;
        if (rd_en)
            o_rdata <= mem[rd_ptr];         // Visible the cycle after the strobe
    end

endmodule

/* common/csb_cmd_if.sv */
`timescale 1ns/100ps

interface csb_cmd_if;
    import csb_pkg::*;

    // Decoded command, stable from start to op_done
    op_type_t   op_type;
    stride_t    stride;
    count16_t   op_num;
    count16_t   o_channel_size;
    side_t      o_side_size;
    count16_t   o_surf_size;
    side_t      kernel_size;
    mem_addr_t  weight_addr;
    mem_addr_t  data_addr;
    mem_addr_t  result_addr;
    logic       start;          // One cycle, fields valid

    // Completion back from execute
    logic       op_done;        // One cycle at end of the layer
    logic       skipped;        // Qualified by op_done

    modport dec (output op_type, stride, op_num, o_channel_size, o_side_size, o_surf_size,
                 kernel_size, weight_addr, data_addr, result_addr, start,
                 input  op_done, skipped);

    modport exe (input  op_type, stride, op_num, o_channel_size, o_side_size, o_surf_size,
                 kernel_size, weight_addr, data_addr, result_addr, start,
                 output op_done, skipped);

endinterface

/* common/csb_pkg.sv */
`include "csb_settings.svh"

package csb_pkg;

    // Raw word as written by the host
    typedef logic [31:0] cmd_word_t;

    // Command fields
    typedef logic [2:0]  op_type_t;     // 1-3 conv, 4 max pool, 5 ave pool
    typedef logic [3:0]  stride_t;      // Step between output pixels
    typedef logic [15:0] count16_t;     // op_num, channel and surface sizes
    typedef logic [7:0]  side_t;        // Side length or kernel size

    // Addresses
    typedef logic [29:0] burst_addr_t;  // 16-byte burst units
    typedef logic [31:0] mem_addr_t;    // Plain byte address

    // FIFO fill level, one extra bit so a full FIFO can be told apart
    typedef logic [`CSB_FIFO_AW:0] fifo_cnt_t;

    // Sequencer states
    typedef enum logic [2:0] {
        idle    = 3'd0,     // Waiting for op enable
        collect = 3'd1,     // Pulling one command from the FIFO
        issue   = 3'd2,     // Fields valid, start goes out
        wait_op = 3'd3,     // Engine busy on the layer
        finish  = 3'd4      // FIFO drained, held until reset
    } csb_state_t;

endpackage

/* common/csb_settings.svh */
`ifndef CSB_SETTINGS_SVH
`define CSB_SETTINGS_SVH

// Command framing
`define CSB_CMD_WORDS   8       // 32-bit words per layer command

// Command FIFO geometry
`define CSB_FIFO_DEPTH  32      // Room for four full commands
`define CSB_FIFO_AW     5       // log2 of the depth

// Output channels the engines finish in one pass over the surface
`define CSB_PARA        16

`endif
